//--- Bender.yml
package:
  name: dpr_alu

sources:
  - files:
      - logic/alu_pkg.sv
      - logic/operand_if.sv
      - logic/result_if.sv
      - logic/arith_unit.sv
      - logic/div_unit.sv
      - logic/result_select.sv
      - logic/alu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_alu.sv

//--- dpr_alu.f
+incdir+tests
logic/alu_pkg.sv
logic/operand_if.sv
logic/result_if.sv
logic/arith_unit.sv
logic/div_unit.sv
logic/result_select.sv
logic/alu_top.sv
tests/tb_alu.sv

//--- logic/alu_pkg.sv
package alu_pkg;

  // Operand and result width
  localparam int DATA_WIDTH = 16;

  // Low bits of b that carry the shift amount
  localparam int SHAMT_WIDTH = 4;

  localparam int OP_WIDTH = 5;

  // Operation codes on op_sel, anything above OP_SUB reads as zero
  localparam logic [OP_WIDTH-1:0] OP_ADD = OP_WIDTH'(0);
  localparam logic [OP_WIDTH-1:0] OP_DEC = OP_WIDTH'(1);
  localparam logic [OP_WIDTH-1:0] OP_DIV = OP_WIDTH'(2);
  localparam logic [OP_WIDTH-1:0] OP_INC = OP_WIDTH'(3);
  localparam logic [OP_WIDTH-1:0] OP_MOD = OP_WIDTH'(4);
  localparam logic [OP_WIDTH-1:0] OP_MUL = OP_WIDTH'(5);
  localparam logic [OP_WIDTH-1:0] OP_MUX = OP_WIDTH'(6);
  localparam logic [OP_WIDTH-1:0] OP_REG = OP_WIDTH'(7);
  localparam logic [OP_WIDTH-1:0] OP_SHL = OP_WIDTH'(8);
  localparam logic [OP_WIDTH-1:0] OP_SHR = OP_WIDTH'(9);
  localparam logic [OP_WIDTH-1:0] OP_SUB = OP_WIDTH'(10);

  // Shift view of an operand word
  typedef struct packed {
    logic [DATA_WIDTH-SHAMT_WIDTH-1:0] unused;
    logic [SHAMT_WIDTH-1:0]            shamt;
  } shift_view_t;

  // One operand word, read either as data or as a shift amount
  typedef union packed {
    logic [DATA_WIDTH-1:0] data;
    shift_view_t           shift;
  } operand_u;

endpackage

//--- logic/alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [DATA_WIDTH-1:0] a_i,
  input  logic [DATA_WIDTH-1:0] b_i,
  input  logic [OP_WIDTH-1:0]   op_sel_i,
  input  logic                  mux_sel_i,
  output logic [DATA_WIDTH-1:0] out_o,
  output logic                  comp_lt_o,
  output logic                  comp_gt_o,
  output logic                  comp_eq_o
);

  operand_if ops ();
  result_if  res ();

  assign ops.a.data  = a_i;
  assign ops.b.data  = b_i;
  assign ops.op_sel  = op_sel_i;
  assign ops.mux_sel = mux_sel_i;

  arith_unit u_arith (
    .ops (ops),
    .res (res)
  );

  div_unit u_div (
    .ops (ops),
    .res (res)
  );

  // Single register stage for every op
  result_select u_select (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .ops       (ops),
    .res       (res),
    .out_o     (out_o),
    .comp_lt_o (comp_lt_o),
    .comp_gt_o (comp_gt_o),
    .comp_eq_o (comp_eq_o)
  );

endmodule

//--- logic/arith_unit.sv
`timescale 1ns/1ps

module arith_unit import alu_pkg::*; (
  operand_if.unit  ops,
  result_if.arith  res
);

  logic [DATA_WIDTH-1:0]  a_word;
  logic [DATA_WIDTH-1:0]  b_word;
  logic [SHAMT_WIDTH-1:0] shamt;

  // Extra top bit holds the borrow
  logic [DATA_WIDTH:0]    diff_ext;
  logic                   borrow;
  logic                   zero;

  assign a_word = ops.a.data;
  assign b_word = ops.b.data;
  assign shamt  = ops.b.shift.shamt;

  // Adders
  assign res.add_sum = a_word + b_word;
  assign res.inc_d   = a_word + DATA_WIDTH'(1);
  assign res.dec_d   = a_word - DATA_WIDTH'(1);

  // Subtract shared with the compare
  assign diff_ext     = {1'b0, a_word} - {1'b0, b_word};
  assign res.sub_diff = diff_ext[DATA_WIDTH-1:0];

  // Product truncated to the operand width
  assign res.mul_prod = a_word * b_word;

  // Logical shifts, zero fill
  assign res.shl_d = a_word << shamt;
  assign res.shr_d = a_word >> shamt;

  // a < b exactly when the subtract borrows
  assign borrow = diff_ext[DATA_WIDTH];
  assign zero   = (diff_ext[DATA_WIDTH-1:0] == '0);

  assign res.lt = borrow;
  assign res.eq = zero;
  assign res.gt = ~borrow & ~zero;

endmodule

//--- logic/div_unit.sv
`timescale 1ns/1ps

module div_unit import alu_pkg::*; (
  operand_if.unit  ops,
  result_if.div    res
);

  logic [DATA_WIDTH-1:0] a_word;
  logic [DATA_WIDTH-1:0] b_word;
  logic [DATA_WIDTH-1:0] quot_bits;

  // Partial remainder entering each stage, last entry is the final remainder
  logic [DATA_WIDTH-1:0] part_rem [DATA_WIDTH+1];

  assign a_word      = ops.a.data;
  assign b_word      = ops.b.data;
  assign part_rem[0] = '0;

  // One stage per quotient bit, MSB first
  // With b of zero no trial ever goes negative, so the quotient is all ones
  // and the remainder walks up to a
  for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_stage
    logic [DATA_WIDTH:0] shifted;
    logic [DATA_WIDTH:0] trial;
    logic                neg;

    assign shifted = {part_rem[i], a_word[DATA_WIDTH-1-i]};
    assign trial   = shifted - {1'b0, b_word};
    assign neg     = trial[DATA_WIDTH];

    assign quot_bits[DATA_WIDTH-1-i] = ~neg;

    // Restore the shifted value when the trial subtract went negative
    assign part_rem[i+1] = neg ? shifted[DATA_WIDTH-1:0] : trial[DATA_WIDTH-1:0];
  end

  assign res.quot = quot_bits;
  assign res.rem  = part_rem[DATA_WIDTH];

endmodule

//--- logic/operand_if.sv
`timescale 1ns/1ps

interface operand_if import alu_pkg::*; ();

  operand_u              a;
  operand_u              b;
  logic [OP_WIDTH-1:0]   op_sel;
  logic                  mux_sel;

  // Plain data view of b for the selector
  logic [DATA_WIDTH-1:0] b_word;

  assign b_word = b.data;

  // Arithmetic and divide units
  modport unit (
    input a,
    input b
  );

  modport sel (
    input a,
    input op_sel,
    input mux_sel,
    input b_word
  );

endinterface

//--- logic/result_if.sv
`timescale 1ns/1ps

interface result_if import alu_pkg::*; ();

  logic [DATA_WIDTH-1:0] add_sum;
  logic [DATA_WIDTH-1:0] sub_diff;
  logic [DATA_WIDTH-1:0] inc_d;
  logic [DATA_WIDTH-1:0] dec_d;
  logic [DATA_WIDTH-1:0] mul_prod;
  logic [DATA_WIDTH-1:0] shl_d;
  logic [DATA_WIDTH-1:0] shr_d;
  logic [DATA_WIDTH-1:0] quot;
  logic [DATA_WIDTH-1:0] rem;

  // Unsigned compare of a against b
  logic                  lt;
  logic                  gt;
  logic                  eq;

  modport arith (
    output add_sum,
    output sub_diff,
    output inc_d,
    output dec_d,
    output mul_prod,
    output shl_d,
    output shr_d,
    output lt,
    output gt,
    output eq
  );

  modport div (
    output quot,
    output rem
  );

  modport sel (
    input add_sum,
    input sub_diff,
    input inc_d,
    input dec_d,
    input mul_prod,
    input shl_d,
    input shr_d,
    input quot,
    input rem,
    input lt,
    input gt,
    input eq
  );

endinterface

//--- logic/result_select.sv
`timescale 1ns/1ps

module result_select import alu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n_i,
  operand_if.sel                ops,
  result_if.sel                 res,
  output logic [DATA_WIDTH-1:0] out_o,
  output logic                  comp_lt_o,
  output logic                  comp_gt_o,
  output logic                  comp_eq_o
);

  logic [DATA_WIDTH-1:0] sel_word;
  logic [DATA_WIDTH-1:0] mux_d;

  // a from the previous edge
  logic [DATA_WIDTH-1:0] reg_q;

  assign mux_d = ops.mux_sel ? ops.b_word : ops.a.data;

  always_comb begin
    case (ops.op_sel)
      OP_ADD:  sel_word = res.add_sum;
      OP_DEC:  sel_word = res.dec_d;
      OP_DIV:  sel_word = res.quot;
      OP_INC:  sel_word = res.inc_d;
      OP_MOD:  sel_word = res.rem;
      OP_MUL:  sel_word = res.mul_prod;
      OP_MUX:  sel_word = mux_d;
      OP_REG:  sel_word = reg_q;
      OP_SHL:  sel_word = res.shl_d;
      OP_SHR:  sel_word = res.shr_d;
      OP_SUB:  sel_word = res.sub_diff;
      default: sel_word = '0;
    endcase
  end

  // Hold stage, loads a on every edge whatever the op
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      reg_q <= '0;
    end else begin
      reg_q <= ops.a.data;
    end
  end

  // Output stage
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_o     <= '0;
      comp_lt_o <= 1'b0;
      comp_gt_o <= 1'b0;
      comp_eq_o <= 1'b0;
    end else begin
      out_o     <= sel_word;
      comp_lt_o <= res.lt;
      comp_gt_o <= res.gt;
      comp_eq_o <= res.eq;
    end
  end

endmodule

//--- tests/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Quotient with the divide-by-zero rule, all ones when b is zero
function automatic logic [DATA_WIDTH-1:0] div_quotient(
  input logic [DATA_WIDTH-1:0] a,
  input logic [DATA_WIDTH-1:0] b
);
  if (b == '0) begin
    return '1;
  end
  return a / b;
endfunction

// Remainder equals a when b is zero
function automatic logic [DATA_WIDTH-1:0] div_remainder(
  input logic [DATA_WIDTH-1:0] a,
  input logic [DATA_WIDTH-1:0] b
);
  if (b == '0) begin
    return a;
  end
  return a % b;
endfunction

// Expected out word, held_a is the a seen on the edge before
function automatic logic [DATA_WIDTH-1:0] compute_expected(
  input logic [OP_WIDTH-1:0]   op,
  input logic [DATA_WIDTH-1:0] a,
  input logic [DATA_WIDTH-1:0] b,
  input logic                  mux_sel,
  input logic [DATA_WIDTH-1:0] held_a
);
  logic [2*DATA_WIDTH-1:0] full_prod;
  int unsigned             shamt;

  full_prod = a * b;
  shamt     = b % (1 << SHAMT_WIDTH);
  case (op)
    OP_ADD:  return DATA_WIDTH'(a + b);
    OP_DEC:  return DATA_WIDTH'(a - 1);
    OP_DIV:  return div_quotient(a, b);
    OP_INC:  return DATA_WIDTH'(a + 1);
    OP_MOD:  return div_remainder(a, b);
    OP_MUL:  return full_prod[DATA_WIDTH-1:0];
    OP_MUX:  return mux_sel ? b : a;
    OP_REG:  return held_a;
    OP_SHL:  return DATA_WIDTH'(a << shamt);
    OP_SHR:  return a >> shamt;
    OP_SUB:  return DATA_WIDTH'(a - b);
    default: return '0;
  endcase
endfunction

// Unsigned compare packed as {lt, gt, eq}
function automatic logic [2:0] compare_flags(
  input logic [DATA_WIDTH-1:0] a,
  input logic [DATA_WIDTH-1:0] b
);
  return {a < b, a > b, a == b};
endfunction

`endif

//--- tests/tb_alu.sv
`timescale 1ns/1ps

module tb_alu import alu_pkg::*; ();

  `include "alu_model.svh"

  localparam int CLK_PERIOD  = 40;
  localparam int RESET_CYCLES = 16;
  localparam int ARITH_COUNT = 300;
  localparam int DIV_COUNT   = 100;
  localparam int MISC_COUNT  = 100;
  localparam int FLAG_COUNT  = 120;
  // Every cycle of every test, plus a flush per test and some slack
  localparam int TEST_CYCLES = RESET_CYCLES + 2 + ARITH_COUNT + DIV_COUNT
                             + MISC_COUNT + FLAG_COUNT + 5;
  localparam int TIMEOUT_NS  = (TEST_CYCLES + 200) * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n_i;
  logic [DATA_WIDTH-1:0] a_i;
  logic [DATA_WIDTH-1:0] b_i;
  logic [OP_WIDTH-1:0]   op_sel_i;
  logic                  mux_sel_i;
  logic [DATA_WIDTH-1:0] out_o;
  logic                  comp_lt_o;
  logic                  comp_gt_o;
  logic                  comp_eq_o;

  // Expected result of the inputs already in flight
  logic                  pend_valid;
  logic [DATA_WIDTH-1:0] pend_out;
  logic [2:0]            pend_flags;

  int error_count;
  int test_errors;
  int check_count;
  int tests_run;
  int tests_failed;

  alu_top UUT (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .op_sel_i  (op_sel_i),
    .mux_sel_i (mux_sel_i),
    .out_o     (out_o),
    .comp_lt_o (comp_lt_o),
    .comp_gt_o (comp_gt_o),
    .comp_eq_o (comp_eq_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the DUT run did not complete", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic check_outputs(input logic [DATA_WIDTH-1:0] exp_out, input logic [2:0] exp_flags);
    check_value("out_o", exp_out, out_o);
    check_value("comp_lt_o", DATA_WIDTH'(exp_flags[2]), DATA_WIDTH'(comp_lt_o));
    check_value("comp_gt_o", DATA_WIDTH'(exp_flags[1]), DATA_WIDTH'(comp_gt_o));
    check_value("comp_eq_o", DATA_WIDTH'(exp_flags[0]), DATA_WIDTH'(comp_eq_o));
  endtask

  // One operation per clock, the previous one is checked mid-cycle
  task automatic run_cycle(input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                           input logic [OP_WIDTH-1:0] op, input logic mux);
    logic [DATA_WIDTH-1:0] held_a;

    @(posedge clk);
    held_a = a_i;
    a_i       <= a;
    b_i       <= b;
    op_sel_i  <= op;
    mux_sel_i <= mux;
    @(negedge clk);
    if (pend_valid) begin
      check_outputs(pend_out, pend_flags);
    end
    pend_out   = compute_expected(op, a, b, mux, held_a);
    pend_flags = compare_flags(a, b);
    pend_valid = 1'b1;
  endtask

  task automatic flush_pipe();
    @(posedge clk);
    @(negedge clk);
    if (pend_valid) begin
      check_outputs(pend_out, pend_flags);
    end
    pend_valid = 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: FAILED with %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    logic [OP_WIDTH-1:0]   arith_ops [5];
    logic [OP_WIDTH-1:0]   misc_ops [4];
    logic [DATA_WIDTH-1:0] ra;
    logic [DATA_WIDTH-1:0] rb;
    logic [OP_WIDTH-1:0]   rop;

    arith_ops = '{OP_ADD, OP_SUB, OP_INC, OP_DEC, OP_MUL};
    misc_ops  = '{OP_SHL, OP_SHR, OP_MUX, OP_REG};
    rst_n_i      = 1'b0;
    a_i          = '0;
    b_i          = '0;
    op_sel_i     = '0;
    mux_sel_i    = 1'b0;
    pend_valid   = 1'b0;
    error_count  = 0;
    test_errors  = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h19ca));

    // Outputs stay cleared while reset is held and right after release
    // Random add operands keep the datapath busy under reset
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      ra  = DATA_WIDTH'($urandom());
      a_i <= ra;
      b_i <= (i % 3 == 0) ? ra : DATA_WIDTH'($urandom());
      @(negedge clk);
      check_outputs('0, 3'b000);
    end
    @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_outputs('0, 3'b000);
    finish_test("reset");

    for (int i = 0; i < ARITH_COUNT; i++) begin
      ra  = DATA_WIDTH'($urandom());
      rb  = DATA_WIDTH'($urandom());
      rop = arith_ops[$urandom() % 5];
      run_cycle(ra, rb, rop, 1'($urandom()));
    end
    flush_pipe();
    finish_test("arithmetic");

    // Two of every eight divisors forced to zero, one for each op
    for (int i = 0; i < DIV_COUNT; i++) begin
      ra = DATA_WIDTH'($urandom());
      rb = (i % 8 < 2) ? '0 : DATA_WIDTH'($urandom()) >> ($urandom() % 16);
      rop = (i % 2 == 0) ? OP_DIV : OP_MOD;
      run_cycle(ra, rb, rop, 1'b0);
    end
    flush_pipe();
    finish_test("divide and modulo");

    // A run of back-to-back register ops in the middle
    for (int i = 0; i < MISC_COUNT; i++) begin
      ra  = DATA_WIDTH'($urandom());
      rb  = DATA_WIDTH'($urandom());
      rop = (i >= 40 && i < 60) ? OP_REG : misc_ops[$urandom() % 4];
      run_cycle(ra, rb, rop, 1'($urandom()));
    end
    flush_pipe();
    finish_test("shifts, mux and register");

    // Walks all unused codes, a equals b every fourth cycle
    for (int i = 0; i < FLAG_COUNT; i++) begin
      ra  = DATA_WIDTH'($urandom());
      rb  = (i % 4 == 0) ? ra : DATA_WIDTH'($urandom());
      rop = OP_WIDTH'(11 + (i % 21));
      run_cycle(ra, rb, rop, 1'($urandom()));
    end
    flush_pipe();
    finish_test("flags and unused codes");

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule
